/* Bender.yml */
package:
  name: spi_master

sources:
  - logic/spi_pkg.sv
  - logic/spi_fifo.sv
  - logic/spi_master_engine.sv
  - logic/spi_regs.sv
  - logic/spi_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/spi_asserts.sv
      - test/spi_tb.sv

/* all.f */
logic/spi_pkg.sv
logic/spi_fifo.sv
logic/spi_master_engine.sv
logic/spi_regs.sv
logic/spi_top.sv
test/tb_clock.sv
test/spi_asserts.sv
test/spi_tb.sv

/* logic/spi_fifo.sv */
// single-clock fall-through byte FIFO with fill count, one instance each for tx and rx
`timescale 1ns/1ps

module spi_fifo (
    input  logic           clk,
    input  logic           n_reset,
    input  logic           push,
    input  spi_pkg::data_t din,
    input  logic           pop,
    output spi_pkg::data_t dout,
    output logic           full,
    output logic           empty,
    output spi_pkg::fill_t fill
);

    spi_pkg::data_t                      mem [spi_pkg::fifo_depth];
    logic [spi_pkg::fifo_addr_width-1:0] wr_ptr;
    logic [spi_pkg::fifo_addr_width-1:0] rd_ptr;
    logic                                do_push;
    logic                                do_pop;

    assign full    = (fill == spi_pkg::fill_t'(spi_pkg::fifo_depth));
    assign empty   = (fill == '0);
    assign do_push = push && !full;    // dropped when full
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];      // head always visible

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;     // both or neither
            endcase
        end
    end

endmodule

/* logic/spi_master_engine.sv */
// spi master shift engine, pulls bytes from the tx FIFO and pushes received bytes to rx
`timescale 1ns/1ps

module spi_master_engine (
    input  logic              clk,
    input  logic              n_reset,
    input  spi_pkg::div_t     divider,
    input  logic              cpol,
    input  logic              cpha,
    input  spi_pkg::ss_sel_t  active_ss,
    input  logic              tx_ena,
    input  logic              rx_ena,
    input  spi_pkg::data_t    tx_dout,
    input  logic              tx_empty,
    output logic              tx_pop,
    output spi_pkg::data_t    rx_din,
    output logic              rx_push,
    input  logic              rx_full,
    output logic              rx_overflow,
    output logic              busy,
    output logic              sclk,
    output logic              mosi,
    input  logic              miso,
    output logic [3:0]        ss
);

    spi_pkg::engine_state_t state;
    logic [15:0]            half_cnt;     // clk cycles within one sclk half period
    logic [15:0]            half_last;
    logic [3:0]             edge_cnt;     // 16 sclk edges per frame
    logic                   sclk_phase;
    logic                   sclk_edge;
    logic                   leading;
    logic                   start;
    spi_pkg::data_t         tx_sr;
    spi_pkg::data_t         rx_sr;

    assign half_last = (16'd1 << divider) - 16'd1;
    assign sclk_edge = (state == spi_pkg::shift) && (half_cnt >= half_last);
    assign leading   = !edge_cnt[0];
    // next frame may start from idle or straight out of the gap
    assign start     = (state != spi_pkg::shift) && tx_ena && !tx_empty;

    assign tx_pop      = start;
    assign busy        = (state != spi_pkg::idle);
    assign rx_push     = (state == spi_pkg::gap) && rx_ena && !rx_full;
    assign rx_overflow = (state == spi_pkg::gap) && rx_ena && rx_full;   // byte is lost
    assign rx_din      = rx_sr;
    assign mosi        = tx_sr[7];                  // msb first
    assign sclk        = sclk_phase ^ cpol;         // rests at cpol
    // ss stays low across back-to-back frames
    assign ss          = busy ? ~(4'b0001 << active_ss) : 4'b1111;

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            state      <= spi_pkg::idle;
            half_cnt   <= '0;
            edge_cnt   <= '0;
            sclk_phase <= 1'b0;
            tx_sr      <= '0;
        end else begin
            if (start) begin
                state    <= spi_pkg::shift;
                half_cnt <= '0;
                edge_cnt <= '0;
                tx_sr    <= tx_dout;
            end else if (state == spi_pkg::gap) begin
                state <= spi_pkg::idle;     // tx drained, ss rises
            end else if (sclk_edge) begin
                half_cnt   <= '0;
                edge_cnt   <= edge_cnt + 4'd1;
                sclk_phase <= !sclk_phase;
                if (edge_cnt == 4'd15)
                    state <= spi_pkg::gap;
                // drive edge: trailing for cpha 0, leading after the first for cpha 1
                if ((leading == cpha) && (edge_cnt != 4'd0))
                    tx_sr <= {tx_sr[6:0], 1'b0};
            end else if (state == spi_pkg::shift) begin
                half_cnt <= half_cnt + 16'd1;
            end
        end
    end

    // sample on the edge opposite to the drive edge
    always_ff @(posedge clk) begin
        if (sclk_edge && (leading != cpha))
            rx_sr <= {rx_sr[6:0], miso};
    end

endmodule

/* logic/spi_pkg.sv */
// shared widths, register map and types for the spi master, referenced by scoped names
package spi_pkg;

    localparam int data_width      = 8;
    localparam int fifo_addr_width = 3;
    localparam int fifo_depth      = 2 ** fifo_addr_width;
    localparam int fill_width      = fifo_addr_width + 1;
    localparam int bus_width       = 32;
    localparam int div_width       = 4;
    localparam int ss_width        = 2;

    typedef logic [data_width-1:0] data_t;
    typedef logic [bus_width-1:0]  bus_t;
    typedef logic [fill_width-1:0] fill_t;
    typedef logic [div_width-1:0]  div_t;
    typedef logic [ss_width-1:0]   ss_sel_t;

    typedef enum logic [1:0] {
        idle,
        shift,
        gap     // one cycle between frames
    } engine_state_t;

    // byte offsets from base_addr
    localparam bus_t        base_addr      = '0;
    localparam int unsigned data_offset    = 0;
    localparam int unsigned ctrl_offset    = 4;
    localparam int unsigned tx_stat_offset = 16;
    localparam int unsigned rx_stat_offset = 28;

    localparam logic [1:0] trans_nonseq = 2'b10;   // bit 1 alone marks a transfer

    // control register
    localparam int ctrl_div_lsb = 0;
    localparam int ctrl_cpha    = 4;
    localparam int ctrl_cpol    = 5;
    localparam int ctrl_ss_lsb  = 8;

    // tx and rx status registers share one layout
    localparam int stat_fill_lsb = 0;
    localparam int stat_wm_lsb   = 8;
    localparam int stat_full     = 16;
    localparam int stat_empty    = 17;
    localparam int stat_wm_hit   = 18;
    localparam int stat_ovf      = 19;
    localparam int stat_udf      = 20;   // rx only
    localparam int stat_ie_lsb   = 24;
    localparam int stat_ena      = 31;

    localparam div_t  div_reset    = 4'd1;   // sclk = clk / 4
    localparam fill_t tx_wm_reset  = '0;
    localparam fill_t rx_wm_reset  = 4'd1;
    localparam logic  tx_ena_reset = 1'b1;
    localparam logic  rx_ena_reset = 1'b1;

endpackage

/* logic/spi_regs.sv */
// AHB-Lite register block of the spi master with control, status, error flags and irq
`timescale 1ns/1ps

module spi_regs (
    input  logic              clk,
    input  logic              n_reset,
    input  spi_pkg::bus_t     haddr,
    input  logic              hwrite,
    input  logic [1:0]        htrans,
    input  spi_pkg::bus_t     hwdata,
    output spi_pkg::bus_t     hrdata,
    output logic              tx_push,
    output spi_pkg::data_t    tx_din,
    input  spi_pkg::fill_t    tx_fill,
    input  logic              tx_full,
    input  logic              tx_empty,
    output logic              rx_pop,
    input  spi_pkg::data_t    rx_dout,
    input  spi_pkg::fill_t    rx_fill,
    input  logic              rx_full,
    input  logic              rx_empty,
    input  logic              busy,
    input  logic              rx_overflow,
    output spi_pkg::div_t     divider,
    output logic              cpol,
    output logic              cpha,
    output spi_pkg::ss_sel_t  active_ss,
    output logic              tx_ena,
    output logic              rx_ena,
    output logic              irq
);

    logic           trans_q;      // registered address phase
    logic           write_q;
    spi_pkg::bus_t  addr_q;
    logic           rd_req;
    logic           wr_ctrl;
    logic           wr_tx_stat;
    logic           wr_rx_stat;
    spi_pkg::fill_t tx_wm;
    spi_pkg::fill_t rx_wm;
    logic [3:0]     tx_ie;        // ready, ovf, wm, empty
    logic [3:0]     rx_ie;        // udf, ovf, wm, full
    logic           tx_ovf;
    logic           rx_ovf;
    logic           rx_udf;
    logic           tx_wm_hit;
    logic           rx_wm_hit;
    logic           tx_ready;
    spi_pkg::bus_t  ctrl_word;

    function automatic logic hit(input spi_pkg::bus_t addr, input int unsigned offset);
        return addr == spi_pkg::bus_t'(spi_pkg::base_addr + offset);
    endfunction

    function automatic spi_pkg::bus_t stat_word(
        input spi_pkg::fill_t fill, input spi_pkg::fill_t wm, input logic full,
        input logic empty, input logic wm_hit, input logic ovf, input logic udf,
        input logic [3:0] ie, input logic ena
    );
        spi_pkg::bus_t w;
        w = '0;
        w[spi_pkg::stat_fill_lsb +: spi_pkg::fill_width] = fill;
        w[spi_pkg::stat_wm_lsb +: spi_pkg::fill_width]   = wm;
        w[spi_pkg::stat_full]                           = full;
        w[spi_pkg::stat_empty]                          = empty;
        w[spi_pkg::stat_wm_hit]                         = wm_hit;
        w[spi_pkg::stat_ovf]                            = ovf;
        w[spi_pkg::stat_udf]                            = udf;
        w[spi_pkg::stat_ie_lsb +: 4]                    = ie;
        w[spi_pkg::stat_ena]                            = ena;
        return w;
    endfunction

    assign rd_req     = htrans[1] && !hwrite;
    assign rx_pop     = rd_req && hit(haddr, spi_pkg::data_offset);
    assign tx_push    = trans_q && write_q && hit(addr_q, spi_pkg::data_offset);
    assign tx_din     = hwdata[spi_pkg::data_width-1:0];
    assign wr_ctrl    = trans_q && write_q && hit(addr_q, spi_pkg::ctrl_offset);
    assign wr_tx_stat = trans_q && write_q && hit(addr_q, spi_pkg::tx_stat_offset);
    assign wr_rx_stat = trans_q && write_q && hit(addr_q, spi_pkg::rx_stat_offset);

    assign tx_wm_hit = (tx_fill <= tx_wm);
    assign rx_wm_hit = (rx_fill >= rx_wm);
    assign tx_ready  = !busy;

    assign irq = |(tx_ie & {tx_ready, tx_ovf, tx_wm_hit, tx_empty}) ||
                 |(rx_ie & {rx_udf, rx_ovf, rx_wm_hit, rx_full});

    always_comb begin
        ctrl_word = '0;
        ctrl_word[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width] = divider;
        ctrl_word[spi_pkg::ctrl_cpha]                          = cpha;
        ctrl_word[spi_pkg::ctrl_cpol]                          = cpol;
        ctrl_word[spi_pkg::ctrl_ss_lsb +: spi_pkg::ss_width]   = active_ss;
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            trans_q <= 1'b0;
            write_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            trans_q <= htrans[1];
            write_q <= hwrite;
            addr_q  <= haddr;
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            divider   <= spi_pkg::div_reset;
            cpol      <= 1'b0;
            cpha      <= 1'b0;
            active_ss <= '0;
        end else if (wr_ctrl) begin
            divider   <= hwdata[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width];
            cpol      <= hwdata[spi_pkg::ctrl_cpol];
            cpha      <= hwdata[spi_pkg::ctrl_cpha];
            active_ss <= hwdata[spi_pkg::ctrl_ss_lsb +: spi_pkg::ss_width];
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            tx_ena <= spi_pkg::tx_ena_reset;
            rx_ena <= spi_pkg::rx_ena_reset;
            tx_ie  <= '0;
            rx_ie  <= '0;
            tx_wm  <= spi_pkg::tx_wm_reset;
            rx_wm  <= spi_pkg::rx_wm_reset;
            tx_ovf <= 1'b0;
            rx_ovf <= 1'b0;
            rx_udf <= 1'b0;
        end else begin
            if (wr_tx_stat) begin
                tx_ena <= hwdata[spi_pkg::stat_ena];
                tx_ie  <= hwdata[spi_pkg::stat_ie_lsb +: 4];
                tx_wm  <= hwdata[spi_pkg::stat_wm_lsb +: spi_pkg::fill_width];  // upper bits unused
            end
            if (wr_rx_stat) begin
                rx_ena <= hwdata[spi_pkg::stat_ena];
                rx_ie  <= hwdata[spi_pkg::stat_ie_lsb +: 4];
                rx_wm  <= hwdata[spi_pkg::stat_wm_lsb +: spi_pkg::fill_width];
            end
            // a new error event wins over a clearing write in the same cycle
            tx_ovf <= (wr_tx_stat ? hwdata[spi_pkg::stat_ovf] : tx_ovf) || (tx_push && tx_full);
            rx_ovf <= (wr_rx_stat ? hwdata[spi_pkg::stat_ovf] : rx_ovf) || rx_overflow;
            rx_udf <= (wr_rx_stat ? hwdata[spi_pkg::stat_udf] : rx_udf) || (rx_pop && rx_empty);
        end
    end

    // read data captured at the address phase, valid one cycle later
    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            hrdata <= '0;
        end else if (rd_req) begin
            if (hit(haddr, spi_pkg::data_offset))
                hrdata <= rx_empty ? '0 : spi_pkg::bus_t'(rx_dout);
            else if (hit(haddr, spi_pkg::ctrl_offset))
                hrdata <= ctrl_word;
            else if (hit(haddr, spi_pkg::tx_stat_offset))
                hrdata <= stat_word(tx_fill, tx_wm, tx_full, tx_empty, tx_wm_hit, tx_ovf,
                                    1'b0, tx_ie, tx_ena);
            else if (hit(haddr, spi_pkg::rx_stat_offset))
                hrdata <= stat_word(rx_fill, rx_wm, rx_full, rx_empty, rx_wm_hit, rx_ovf,
                                    rx_udf, rx_ie, rx_ena);
            else
                hrdata <= '0;   // unmapped
        end
    end

endmodule

/* logic/spi_top.sv */
// spi master top level, register block, tx and rx FIFOs and shift engine on one clock
`timescale 1ns/1ps

module spi_top (
    input  logic          clk,
    input  logic          n_reset,
    input  spi_pkg::bus_t haddr,
    input  logic          hwrite,
    input  logic [1:0]    htrans,
    input  spi_pkg::bus_t hwdata,
    output spi_pkg::bus_t hrdata,
    output logic          hready,
    output logic          hresp,
    output logic          sclk,
    output logic          mosi,
    input  logic          miso,
    output logic [3:0]    ss,
    output logic          irq
);

    logic             tx_push;
    logic             tx_pop;
    spi_pkg::data_t   tx_din;
    spi_pkg::data_t   tx_dout;
    spi_pkg::fill_t   tx_fill;
    logic             tx_full;
    logic             tx_empty;
    logic             rx_push;
    logic             rx_pop;
    spi_pkg::data_t   rx_din;
    spi_pkg::data_t   rx_dout;
    spi_pkg::fill_t   rx_fill;
    logic             rx_full;
    logic             rx_empty;
    logic             rx_overflow;
    logic             busy;
    spi_pkg::div_t    divider;
    logic             cpol;
    logic             cpha;
    spi_pkg::ss_sel_t active_ss;
    logic             tx_ena;
    logic             rx_ena;

    assign hready = 1'b1;   // zero wait states
    assign hresp  = 1'b0;   // always okay

    spi_regs i_regs (
        .clk, .n_reset, .haddr, .hwrite, .htrans, .hwdata, .hrdata,
        .tx_push, .tx_din, .tx_fill, .tx_full, .tx_empty,
        .rx_pop, .rx_dout, .rx_fill, .rx_full, .rx_empty,
        .busy, .rx_overflow,
        .divider, .cpol, .cpha, .active_ss, .tx_ena, .rx_ena, .irq
    );

    spi_fifo i_tx_fifo (
        .clk, .n_reset,
        .push(tx_push), .din(tx_din), .pop(tx_pop), .dout(tx_dout),
        .full(tx_full), .empty(tx_empty), .fill(tx_fill)
    );

    spi_fifo i_rx_fifo (
        .clk, .n_reset,
        .push(rx_push), .din(rx_din), .pop(rx_pop), .dout(rx_dout),
        .full(rx_full), .empty(rx_empty), .fill(rx_fill)
    );

    spi_master_engine i_engine (
        .clk, .n_reset,
        .divider, .cpol, .cpha, .active_ss, .tx_ena, .rx_ena,
        .tx_dout, .tx_empty, .tx_pop,
        .rx_din, .rx_push, .rx_full, .rx_overflow,
        .busy, .sclk, .mosi, .miso, .ss
    );

endmodule

/* test/spi_asserts.sv */
// pin-level assertions for the spi master engine, bound into every engine instance
`timescale 1ns/1ps

module spi_asserts (
    input logic       clk,
    input logic       n_reset,
    input logic       busy,
    input logic       cpol,
    input logic       sclk,
    input logic       rx_push,
    input logic       rx_ena,
    input logic [3:0] ss
);

    int failures = 0;   // failed assertion count, summed into the testbench result

    // sclk must rest at its polarity between bursts
    sclk_rest: assert property (@(posedge clk) disable iff (!n_reset) !busy |-> sclk == cpol)
        else begin
            $error("sclk differs from cpol while the engine is idle");
            failures++;
        end

    one_ss: assert property (@(posedge clk) disable iff (!n_reset) $onehot0(~ss))
        else begin
            $error("more than one slave select is low");
            failures++;
        end

    push_ena: assert property (@(posedge clk) disable iff (!n_reset) rx_push |-> rx_ena)
        else begin
            $error("rx push while rx is disabled");
            failures++;
        end

endmodule

bind spi_master_engine spi_asserts i_asserts (.*);

/* test/spi_tb.sv */
// testbench top, random loopback traffic over the bus checked against a queue model
`timescale 1ns/1ps

module spi_tb;

    localparam int frames      = 120;                    // upper bound over all tests
    localparam int cycle_limit = frames * 8 * 16 + 20000; // divider 3 gives 16 clk per bit
    localparam spi_pkg::bus_t data_addr = spi_pkg::base_addr + spi_pkg::data_offset;
    localparam spi_pkg::bus_t ctrl_addr = spi_pkg::base_addr + spi_pkg::ctrl_offset;
    localparam spi_pkg::bus_t tx_addr   = spi_pkg::base_addr + spi_pkg::tx_stat_offset;
    localparam spi_pkg::bus_t rx_addr   = spi_pkg::base_addr + spi_pkg::rx_stat_offset;

    logic           clk;
    logic           n_reset;
    spi_pkg::bus_t  haddr;
    logic           hwrite;
    logic [1:0]     htrans;
    spi_pkg::bus_t  hwdata;
    spi_pkg::bus_t  hrdata;
    logic           hready;
    logic           hresp;
    logic           sclk;
    logic           mosi;
    logic [3:0]     ss;
    logic           irq;

    spi_pkg::data_t tx_q[$];      // model of both FIFOs
    spi_pkg::data_t rx_q[$];
    int             tx_wm = 0;
    int             rx_wm = 1;
    bit [3:0]       tx_ie = '0;
    bit [3:0]       rx_ie = '0;
    bit             tx_ena = 1'b1;
    bit             tx_ovf = 1'b0;
    bit             rx_ovf = 1'b0;
    bit             rx_udf = 1'b0;
    bit             mon_on = 1'b0;
    logic [3:0]     ss_low;
    logic           sclk_prev;
    int             sclk_edges = 0;
    int             cycles = 0;
    int             checks = 0;
    int             test_err = 0;
    int             errors = 0;
    int             tests = 0;
    int             failed_tests = 0;

    tb_clock i_clock (.clk, .n_reset);

    spi_top i_dut (.*, .miso(mosi));   // loopback

    always @(negedge clk) begin
        if (mon_on) begin
            ss_low = ss_low | ~ss;
            if (ss != 4'hf && sclk !== sclk_prev)
                sclk_edges++;   // each sclk toggle inside a burst
        end
        sclk_prev = sclk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the engine never went idle", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic spi_pkg::bus_t stat_word(input int fill, input int wm, input bit rx,
                                                input bit ovf, input bit udf,
                                                input bit [3:0] ie, input bit ena);
        spi_pkg::bus_t w;
        w = spi_pkg::bus_t'(fill) | (spi_pkg::bus_t'(wm) << spi_pkg::stat_wm_lsb);
        w[spi_pkg::stat_full]   = (fill == 8);
        w[spi_pkg::stat_empty]  = (fill == 0);
        w[spi_pkg::stat_wm_hit] = rx ? (fill >= wm) : (fill <= wm);
        w[spi_pkg::stat_ovf]    = ovf;
        w[spi_pkg::stat_udf]    = udf;
        w[spi_pkg::stat_ie_lsb +: 4] = ie;
        w[spi_pkg::stat_ena]    = ena;
        return w;
    endfunction

    task automatic bus_write(input spi_pkg::bus_t addr, input spi_pkg::bus_t data);
        @(negedge clk);
        haddr  = addr;
        hwrite = 1'b1;
        htrans = spi_pkg::trans_nonseq;
        @(negedge clk);
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = data;
        @(posedge clk);   // data phase ends here
    endtask

    task automatic bus_read(input spi_pkg::bus_t addr, output spi_pkg::bus_t data);
        @(negedge clk);
        haddr  = addr;
        hwrite = 1'b0;
        htrans = spi_pkg::trans_nonseq;
        @(negedge clk);
        htrans = 2'b00;
        data   = hrdata;
    endtask

    task automatic check(input string name, input spi_pkg::bus_t exp, input spi_pkg::bus_t act);
        checks++;
        if (act !== exp) begin
            test_err++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %s (%0d errors)", name, (test_err == 0) ? "ok" : "failed", test_err);
        tests++;
        if (test_err != 0)
            failed_tests++;
        errors   = errors + test_err;
        test_err = 0;
    endtask

    // read-only fields in the word are ignored by the DUT
    task automatic write_stats();
        bus_write(tx_addr, stat_word(0, tx_wm, 0, tx_ovf, 0, tx_ie, tx_ena));
        bus_write(rx_addr, stat_word(0, rx_wm, 1, rx_ovf, rx_udf, rx_ie, 1'b1));
    endtask

    task automatic check_stats();
        spi_pkg::bus_t w;
        bus_read(tx_addr, w);
        check("tx_stat", stat_word(tx_q.size(), tx_wm, 0, tx_ovf, 0, tx_ie, tx_ena), w);
        bus_read(rx_addr, w);
        check("rx_stat", stat_word(rx_q.size(), rx_wm, 1, rx_ovf, rx_udf, rx_ie, 1'b1), w);
    endtask

    task automatic send(input spi_pkg::data_t b);
        bus_write(data_addr, spi_pkg::bus_t'(b));
        if (tx_q.size() == 8)
            tx_ovf = 1'b1;   // byte lost
        else
            tx_q.push_back(b);
    endtask

    // wait for tx empty with ss released, then move the sent bytes into the rx model
    task automatic drain();
        spi_pkg::bus_t w;
        w = '0;
        while (!(w[spi_pkg::stat_empty] && ss == 4'hf))
            bus_read(tx_addr, w);
        while (tx_q.size() > 0) begin
            if (rx_q.size() == 8) begin
                rx_ovf = 1'b1;
                void'(tx_q.pop_front());
            end else begin
                rx_q.push_back(tx_q.pop_front());
            end
        end
    endtask

    task automatic read_rx(input int n);
        spi_pkg::bus_t w;
        spi_pkg::bus_t exp;
        repeat (n) begin
            bus_read(data_addr, w);
            if (rx_q.size() > 0) begin
                exp = spi_pkg::bus_t'(rx_q.pop_front());
            end else begin
                exp    = '0;
                rx_udf = 1'b1;
            end
            check("hrdata", exp, w);
        end
    endtask

    initial begin
        spi_pkg::bus_t w;
        int            sel;
        int            n;
        logic          exp_irq;
        haddr  = '0;
        hwrite = 1'b0;
        htrans = 2'b00;
        hwdata = '0;
        void'($urandom(32'h348bc365));
        @(posedge n_reset);

        bus_read(ctrl_addr, w);
        check("ctrl", 32'h1, w);   // divider 1, everything else 0
        check_stats();
        check("irq", 1'b0, irq);
        check("ss", 4'hf, ss);
        check("hready", 1'b1, hready);
        check("hresp", 1'b0, hresp);
        end_test("reset");

        repeat (6) begin
            sel = $urandom_range(3);
            w   = $urandom_range(3) | ($urandom_range(3) << 4) | (sel << spi_pkg::ctrl_ss_lsb);
            bus_write(ctrl_addr, w);
            n          = $urandom_range(1, 8);
            ss_low     = '0;
            sclk_edges = 0;
            mon_on     = 1'b1;
            repeat (n) send($urandom);
            drain();
            mon_on = 1'b0;
            check("ss low lines", 4'b0001 << sel, ss_low);
            check("sclk edges", 16 * n, sclk_edges);   // two edges per bit
            read_rx(n);
        end
        end_test("loopback");

        bus_write(ctrl_addr, 32'h0);   // fastest sclk from here on
        tx_ena = 1'b0;
        write_stats();
        repeat (9) send($urandom);
        check_stats();
        tx_ovf = 1'b0;
        tx_ena = 1'b1;
        write_stats();
        drain();
        send($urandom);                // ninth frame into a full rx FIFO
        drain();
        check_stats();
        read_rx(9);
        check_stats();
        rx_ovf = 1'b0;
        rx_udf = 1'b0;
        write_stats();
        check_stats();
        end_test("errors");

        repeat (6) begin
            n      = $urandom_range(8);
            tx_ena = 1'b0;
            tx_wm  = $urandom_range(8);
            rx_wm  = $urandom_range(8);
            write_stats();
            repeat (n) send($urandom);
            check_stats();
            tx_ena = 1'b1;
            write_stats();
            drain();
            check_stats();
            read_rx(n);
        end
        end_test("watermarks");

        repeat (12) begin
            tx_ie = $urandom;
            rx_ie = $urandom;
            tx_wm = $urandom_range(8);
            rx_wm = $urandom_range(8);
            write_stats();
            if ($urandom_range(1)) begin
                send($urandom);
                drain();
            end
            @(negedge clk);
            // tx side is idle and empty: ready, empty and watermark are all set
            exp_irq = |(tx_ie & {1'b1, tx_ovf, 1'b1, 1'b1}) ||
                      |(rx_ie & {rx_udf, rx_ovf, rx_q.size() >= rx_wm, rx_q.size() == 8});
            check("irq", exp_irq, irq);
        end
        end_test("interrupt");

        if (i_dut.i_engine.i_asserts.failures != 0)
            $display("bound assertions on the engine failed %0d times",
                     i_dut.i_engine.i_asserts.failures);
        errors = errors + i_dut.i_engine.i_asserts.failures;

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
// testbench clock and reset source, 8 ns clock with reset held low for three cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic n_reset
);

    initial begin
        clk     = 1'b0;
        n_reset = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b1;   // released away from the active edge
    end

endmodule
